//--- verilog.f
+incdir+hw
hw/hc_pkg.sv
hw/tank_adc_capture.sv
hw/bridge_sequencer.sv
hw/bridge_gate_stage.sv
hw/ibat_filter.sv
hw/phase_pi_ctrl.sv
hw/hc_top.sv
testbench/tb_hc_top.sv

//--- testbench/tb_hc_top.sv
// testbench for the resonant converter power-stage core
// random tank samples, start-up, dead time, over-voltage and phase PI
`timescale 1ns/1ps
`include "hc_consts.svh"

module tb_hc_top import hc_pkg::*; ();

   localparam int CYC_NS = 20;
   localparam int ADC_N  = 64;
   localparam int PI_N   = 250;
   localparam int MAN_N  = 8;
   // summed test lengths in cycles
   localparam int TEST_CYCLES = ADC_N + 2 + 2 * (`HC_VG_CNT + 5)
      + `HC_DT_00 + `HC_DT_10 + `HC_DT_01 + `HC_DT_11 + 4 * 3
      + (`HC_DT_10 + 4) + (`HC_DT_10 + 16) + 2 * PI_N * 6 + MAN_N + 2;
   localparam adc_sample_t ADC_MIN = {1'b1, {(`HC_ADC_W-1){1'b0}}};
   localparam adc_sample_t ADC_MAX = {1'b0, {(`HC_ADC_W-1){1'b1}}};

   logic          ADA_DCO = 1'b0;
   logic          i_arst_n;
   adc_sample_t   i_ada_data, i_adb_data;
   logic          i_ada_or, i_ibat_eoc, i_enable, i_phi_manual_sel;
   bat_code_t     i_vbat_code, i_ibat_code;
   logic [1:0]    i_dt_sel;
   gate_t         i_gate_cmd;
   logic [7:0]    i_iref_da;
   phi_t          i_phi_manual;
   adc_sample_t   o_tank_vc, o_tank_ic;
   gate_t         o_q;
   bridge_state_t o_state;
   logic          o_ov_fault;
   phi_t          o_phi;

   // expected values and check enables
   adc_sample_t   exp_vc, exp_ic;
   gate_t         exp_q;
   bridge_state_t exp_state;
   logic          exp_fault;
   phi_t          exp_phi;
   logic          chk_adc, chk_ctl, chk_phi;
   int            err_cnt, chk_cnt;

   // PI reference state
   int            win_m [4];
   int            integ_m;
   logic [15:0]   lfsr = 16'd4;

   hc_top dut (.*);

   always #(CYC_NS / 2) ADA_DCO = ~ADA_DCO;

   // ====================
   // reference models
   // ====================
   // fibonacci LFSR x^16+x^14+x^13+x^11+1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // inverted polarity, clamp on over-range
   function automatic adc_sample_t vc_ref(input adc_sample_t raw, input logic ovr);
      if (!ovr) return -raw;
      return (raw == ADC_MIN) ? ADC_MAX : ADC_MIN;
   endfunction

   function automatic bridge_state_t startup_ref(input int n);
      if (n <= 0) return BR_OFF;
      if (n <= `HC_ON_CNT + 1) return BR_BOOT;
      if (n <= `HC_VG_CNT + 1) return BR_PRECHARGE;
      return BR_RUN;
   endfunction

   function automatic int dt_ref(input logic [1:0] sel);
      case (sel)
         2'b00:   return `HC_DT_00;
         2'b10:   return `HC_DT_10;
         2'b01:   return `HC_DT_01;
         default: return `HC_DT_11;
      endcase
   endfunction

   // timed = command bits whose dead time has run out
   function automatic gate_t gate_ref(input bridge_state_t st, input gate_t timed);
      case (st)
         BR_BOOT:      return 4'b1100;
         BR_PRECHARGE: return 4'b1001;
         BR_RUN:       return ((timed[0] && timed[2]) || (timed[1] && timed[3])) ? '0 : timed;
         default:      return '0;
      endcase
   endfunction

   // one current sample through average, error, anti-windup, clamp
   function automatic phi_t pi_ref(input bat_code_t code, input logic [7:0] iref);
      int mean, err, cand, raw;
      for (int i = 3; i > 0; i--) win_m[i] = win_m[i-1];
      win_m[0] = code * `HC_IBAT_MA_LSB;
      mean = (win_m[0] + win_m[1] + win_m[2] + win_m[3]) / 4;
      err  = (mean / (1 << `HC_ERR_ROUND_SHIFT)) * (1 << `HC_ERR_ROUND_SHIFT)
             - iref * `HC_IREF_SCALE;
      cand = integ_m + err * `HC_KI;
      raw  = ((err * `HC_KP) >>> `HC_KP_SHIFT) + (cand >>> `HC_KI_SHIFT) + `HC_PHI_OFFSET;
      if (!((raw > `HC_PHI_MAX && err > 0) || (raw < 0 && err < 0))) integ_m = cand;
      if (raw < 0) return '0;
      if (raw > `HC_PHI_MAX) return phi_t'(`HC_PHI_MAX);
      return phi_t'(raw);
   endfunction

   // ====================
   // compare
   // ====================
   // outputs settle long before the falling edge
   always @(negedge ADA_DCO) begin
      if (chk_adc) begin
         chk_cnt++;
         assert (o_tank_vc === exp_vc && o_tank_ic === exp_ic) else begin
            err_cnt++;
            $display("ERR %0t: tank vc %0d ic %0d, expected %0d %0d", $time,
                     o_tank_vc, o_tank_ic, exp_vc, exp_ic);
         end
      end
      if (chk_ctl) begin
         chk_cnt++;
         assert (o_state === exp_state && o_q === exp_q && o_ov_fault === exp_fault) else begin
            err_cnt++;
            $display("ERR %0t: state %0d q %b fault %b, expected %0d %b %b", $time,
                     o_state, o_q, o_ov_fault, exp_state, exp_q, exp_fault);
         end
      end
      if (chk_phi) begin
         chk_cnt++;
         assert (o_phi === exp_phi) else begin
            err_cnt++;
            $display("ERR %0t: phi %0d, expected %0d", $time, o_phi, exp_phi);
         end
      end
   end

   // ====================
   // tests
   // ====================
   task automatic test_adc();
      adc_sample_t a, b;
      logic        ovr;
      for (int i = 0; i < ADC_N; i++) begin
         a   = adc_sample_t'(rand_bits(`HC_ADC_W));
         b   = adc_sample_t'(rand_bits(`HC_ADC_W));
         ovr = (rand_bits(3) == 0);
         // hit the negative end under over-range now and then
         if (i % 16 == 5) begin
            a   = ADC_MIN;
            ovr = 1'b1;
         end
         i_ada_data <= a;
         i_adb_data <= b;
         i_ada_or   <= ovr;
         @(posedge ADA_DCO);
         exp_vc  = vc_ref(a, ovr);
         exp_ic  = -b;
         chk_adc = 1'b1;
      end
      i_ada_or <= 1'b0;
      @(posedge ADA_DCO);
      chk_adc = 1'b0;
   endtask

   // enable rise, then boot, precharge and run on fixed counts
   task automatic run_startup();
      i_enable <= 1'b1;
      for (int n = 1; n <= `HC_VG_CNT + 3; n++) begin
         @(posedge ADA_DCO);
         exp_state = startup_ref(n);
         exp_q     = gate_ref(startup_ref(n - 1), '0);
         exp_fault = 1'b0;
      end
   endtask

   task automatic hold_cmd(input gate_t cmd, input logic [1:0] sel, input int extra);
      int len;
      len = dt_ref(sel);
      i_dt_sel   <= sel;
      i_gate_cmd <= cmd;
      for (int n = 1; n <= len + extra; n++) begin
         @(posedge ADA_DCO);
         exp_q = gate_ref(BR_RUN, (n > len) ? cmd : gate_t'(0));
      end
   endtask

   task automatic test_dead_time();
      for (int s = 0; s < 4; s++) begin
         hold_cmd(gate_t'(1 << s), 2'(s), 2);
         // turn-off at the next edge
         i_gate_cmd <= '0;
         @(posedge ADA_DCO);
         exp_q = '0;
      end
      // M1 with M3 on one leg
      hold_cmd(4'b0101, 2'b10, 3);
      i_gate_cmd <= '0;
      @(posedge ADA_DCO);
   endtask

   task automatic test_overvoltage();
      hold_cmd(4'b0001, 2'b10, 2);
      i_vbat_code <= 8'd220;
      @(posedge ADA_DCO);
      exp_state = BR_OFF;
      exp_fault = 1'b1;
      @(posedge ADA_DCO);
      exp_q = '0;
      // no restart while enable stays high
      repeat (5) @(posedge ADA_DCO);
      i_vbat_code <= 8'd100;
      i_gate_cmd  <= '0;
      repeat (5) @(posedge ADA_DCO);
      i_enable <= 1'b0;
      @(posedge ADA_DCO);
      exp_fault = 1'b0;
      @(posedge ADA_DCO);
      run_startup();
   endtask

   task automatic pulse_eoc(input bat_code_t code, input logic [7:0] iref);
      i_ibat_code <= code;
      i_iref_da   <= iref;
      i_ibat_eoc  <= 1'b1;
      repeat (2) @(posedge ADA_DCO);
      i_ibat_eoc <= 1'b0;
      // valid 3 cycles after the fall, phase one later
      repeat (4) @(posedge ADA_DCO);
      exp_phi = pi_ref(code, iref);
   endtask

   task automatic test_pi();
      phi_t pi_phi;
      phi_t man;
      integ_m = 0;
      for (int i = 0; i < 4; i++) win_m[i] = 0;
      // high current first, then low current against a high reference
      for (int k = 0; k < PI_N; k++) pulse_eoc(8'h80 | 8'(rand_bits(7)), 8'(rand_bits(4)));
      for (int k = 0; k < PI_N; k++) pulse_eoc(8'(rand_bits(5)), 8'h80 | 8'(rand_bits(7)));
      pi_phi = exp_phi;
      for (int m = 0; m < MAN_N; m++) begin
         man = phi_t'(rand_bits(8));
         i_phi_manual     <= man;
         i_phi_manual_sel <= 1'b1;
         @(posedge ADA_DCO);
         exp_phi = man;
      end
      i_phi_manual_sel <= 1'b0;
      @(posedge ADA_DCO);
      exp_phi = pi_phi;
      @(posedge ADA_DCO);
   endtask

   task automatic report_test(input string name, input int err_before);
      if (err_cnt == err_before) $display("test %s: ok", name);
      else $display("test %s: %0d errors", name, err_cnt - err_before);
   endtask

   initial begin
      int e0;
      i_arst_n = 1'b0;
      i_ada_data = '0;
      i_adb_data = '0;
      i_ada_or = 1'b0;
      i_vbat_code = 8'd100;
      i_ibat_code = '0;
      i_ibat_eoc = 1'b0;
      i_enable = 1'b0;
      i_dt_sel = 2'b00;
      i_gate_cmd = '0;
      i_iref_da = '0;
      i_phi_manual = '0;
      i_phi_manual_sel = 1'b0;
      chk_adc = 1'b0;
      chk_ctl = 1'b0;
      chk_phi = 1'b0;
      err_cnt = 0;
      chk_cnt = 0;
      repeat (3) @(posedge ADA_DCO);
      i_arst_n <= 1'b1;
      // reset values hold until the first enable
      exp_state = BR_OFF;
      exp_q     = '0;
      exp_fault = 1'b0;
      exp_phi   = phi_t'(`HC_PHI_OFFSET);
      chk_ctl   = 1'b1;
      chk_phi   = 1'b1;
      e0 = err_cnt;
      test_adc();
      report_test("adc capture", e0);
      e0 = err_cnt;
      run_startup();
      report_test("start-up", e0);
      e0 = err_cnt;
      test_dead_time();
      report_test("dead time", e0);
      e0 = err_cnt;
      test_overvoltage();
      report_test("over-voltage", e0);
      e0 = err_cnt;
      test_pi();
      report_test("phase PI and bypass", e0);
      chk_ctl = 1'b0;
      chk_phi = 1'b0;
      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   // watchdog, test length plus margin
   initial begin
      #((TEST_CYCLES + 200) * CYC_NS);
      $display("timeout: tests did not complete within %0d cycles", TEST_CYCLES + 200);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

//--- hw/hc_top.sv
// resonant converter power-stage core
// tank capture, bridge start-up, gate drive and phase PI loop
`timescale 1ns/1ps

module hc_top import hc_pkg::*; (
   input  logic          ADA_DCO,
   input  logic          i_arst_n,
   input  adc_sample_t   i_ada_data,
   input  adc_sample_t   i_adb_data,
   input  logic          i_ada_or,
   input  bat_code_t     i_vbat_code,
   input  bat_code_t     i_ibat_code,
   input  logic          i_ibat_eoc,
   input  logic          i_enable,
   input  logic [1:0]    i_dt_sel,
   input  gate_t         i_gate_cmd,
   input  logic [7:0]    i_iref_da,
   input  phi_t          i_phi_manual,
   input  logic          i_phi_manual_sel,
   output adc_sample_t   o_tank_vc,
   output adc_sample_t   o_tank_ic,
   output gate_t         o_q,
   output bridge_state_t o_state,
   output logic          o_ov_fault,
   output phi_t          o_phi
);

   logic       pi_clear;
   ctrl_word_t ibat_mean_ma;
   logic       ibat_valid;

   // tank samples out to the switching law
   tank_adc_capture u_tank_adc (
      .ADA_DCO(ADA_DCO), .i_arst_n(i_arst_n), .i_ada_data(i_ada_data),
      .i_adb_data(i_adb_data), .i_ada_or(i_ada_or), .o_vc(o_tank_vc), .o_ic(o_tank_ic)
   );

   bridge_sequencer u_seq (
      .ADA_DCO(ADA_DCO), .i_arst_n(i_arst_n), .i_enable(i_enable),
      .i_vbat_code(i_vbat_code), .o_state(o_state), .o_pi_clear(pi_clear),
      .o_ov_fault(o_ov_fault)
   );

   bridge_gate_stage u_gate (
      .ADA_DCO(ADA_DCO), .i_arst_n(i_arst_n), .i_state(o_state),
      .i_gate_cmd(i_gate_cmd), .i_dt_sel(i_dt_sel), .o_q(o_q)
   );

   ibat_filter u_ibat (
      .ADA_DCO(ADA_DCO), .i_arst_n(i_arst_n), .i_ibat_code(i_ibat_code),
      .i_ibat_eoc(i_ibat_eoc), .o_mean_ma(ibat_mean_ma), .o_valid(ibat_valid)
   );

   phase_pi_ctrl u_pi (
      .ADA_DCO(ADA_DCO), .i_arst_n(i_arst_n), .i_state(o_state), .i_clear(pi_clear),
      .i_mean_ma(ibat_mean_ma), .i_valid(ibat_valid), .i_iref_da(i_iref_da),
      .i_phi_manual(i_phi_manual), .i_phi_manual_sel(i_phi_manual_sel), .o_phi(o_phi)
   );

endmodule

//--- hw/phase_pi_ctrl.sv
// phase PI controller
// conditional-integration anti-windup, offset, saturation and manual bypass
`timescale 1ns/1ps
`include "hc_consts.svh"

module phase_pi_ctrl import hc_pkg::*; (
   input  logic          ADA_DCO,
   input  logic          i_arst_n,
   input  bridge_state_t i_state,
   input  logic          i_clear,
   input  ctrl_word_t    i_mean_ma,
   input  logic          i_valid,
   input  logic [7:0]    i_iref_da,
   input  phi_t          i_phi_manual,
   input  logic          i_phi_manual_sel,
   output phi_t          o_phi
);

   ctrl_word_t err;
   ctrl_word_t integ_q;
   ctrl_word_t integ_cand;
   ctrl_word_t raw;
   phi_t       phi_sat;
   phi_t       phi_pi_q;
   phi_t       phi_pi_d;
   logic       aw_hold;

   // ====================
   // PI arithmetic
   // ====================
   always_comb begin
      // mean rounded to dA steps, error in mA
      err = ((i_mean_ma >>> `HC_ERR_ROUND_SHIFT) <<< `HC_ERR_ROUND_SHIFT)
            - ctrl_word_t'({24'd0, i_iref_da}) * `HC_IREF_SCALE;
      integ_cand = integ_q + err * `HC_KI;
      raw = ((err * `HC_KP) >>> `HC_KP_SHIFT) + (integ_cand >>> `HC_KI_SHIFT)
            + `HC_PHI_OFFSET;
      // clamp to 0..max
      if (raw < 0) phi_sat = '0;
      else if (raw > `HC_PHI_MAX) phi_sat = phi_t'(`HC_PHI_MAX);
      else phi_sat = phi_t'(raw);
      // no integration deeper into saturation
      aw_hold = (raw > `HC_PHI_MAX && err > 0) || (raw < 0 && err < 0);
   end

   // new phase only on a valid sample while running
   assign phi_pi_d = (i_state == BR_RUN && !i_clear && i_valid) ? phi_sat : phi_pi_q;

   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         integ_q  <= '0;
         phi_pi_q <= phi_t'(`HC_PHI_OFFSET);
         o_phi    <= phi_t'(`HC_PHI_OFFSET);
      end else begin
         if (i_state != BR_RUN || i_clear) begin
            integ_q  <= '0;
            phi_pi_q <= phi_t'(`HC_PHI_OFFSET);
         end else begin
            if (i_valid && !aw_hold) integ_q <= integ_cand;
            phi_pi_q <= phi_pi_d;
         end
         // manual phase bypasses the loop
         o_phi <= i_phi_manual_sel ? i_phi_manual : phi_pi_d;
      end
   end

endmodule

//--- hw/ibat_filter.sv
// battery current filter
// EOC sync, scaling to mA and a four-sample moving average
`timescale 1ns/1ps
`include "hc_consts.svh"

module ibat_filter import hc_pkg::*; (
   input  logic       ADA_DCO,
   input  logic       i_arst_n,
   input  bat_code_t  i_ibat_code,
   input  logic       i_ibat_eoc,
   output ctrl_word_t o_mean_ma,
   output logic       o_valid
);

   logic [2:0] eoc_sync;
   logic       eoc_fall;
   ctrl_word_t sample_ma;
   ctrl_word_t win [4];
   ctrl_word_t win_sum;

   // two sync flops plus one for edge detect
   assign eoc_fall  = eoc_sync[2] && !eoc_sync[1];
   assign sample_ma = ctrl_word_t'({{(32-`HC_BAT_W){1'b0}}, i_ibat_code}) * `HC_IBAT_MA_LSB;

   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         eoc_sync <= '0;
         o_valid  <= 1'b0;
         for (int i = 0; i < 4; i++) win[i] <= '0;
      end else begin
         eoc_sync <= {eoc_sync[1:0], i_ibat_eoc};
         o_valid  <= eoc_fall;
         // new sample in, oldest out
         if (eoc_fall) begin
            win[0] <= sample_ma;
            for (int i = 1; i < 4; i++) win[i] <= win[i-1];
         end
      end
   end

   // mean over the window
   assign win_sum   = win[0] + win[1] + win[2] + win[3];
   assign o_mean_ma = win_sum >>> 2;

endmodule

//--- hw/bridge_gate_stage.sv
// gate driver stage
// per-device dead time, start-up override and shoot-through guard
`timescale 1ns/1ps
`include "hc_consts.svh"

module bridge_gate_stage import hc_pkg::*; (
   input  logic          ADA_DCO,
   input  logic          i_arst_n,
   input  bridge_state_t i_state,
   input  gate_t         i_gate_cmd,
   input  logic [1:0]    i_dt_sel,
   output gate_t         o_q
);

   typedef logic [`HC_DT_W-1:0] dt_cnt_t;

   dt_cnt_t dt_len;
   dt_cnt_t dt_cnt [4];
   gate_t   dt_on;
   gate_t   q_d;
   logic    leg_clash;

   // dead-time table
   always_comb begin
      case (i_dt_sel)
         2'b00:   dt_len = dt_cnt_t'(`HC_DT_00);
         2'b10:   dt_len = dt_cnt_t'(`HC_DT_10);
         2'b01:   dt_len = dt_cnt_t'(`HC_DT_01);
         default: dt_len = dt_cnt_t'(`HC_DT_11);
      endcase
   end

   // counts continuous high time of each command bit
   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < 4; i++) dt_cnt[i] <= '0;
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (i_state != BR_RUN || !i_gate_cmd[i]) dt_cnt[i] <= '0;
            else if (dt_cnt[i] < dt_len) dt_cnt[i] <= dt_cnt[i] + 1'b1;
         end
      end
   end

   // turn-on delayed, turn-off immediate
   always_comb begin
      for (int i = 0; i < 4; i++) dt_on[i] = i_gate_cmd[i] && (dt_cnt[i] >= dt_len);
   end

   // both devices of one leg
   assign leg_clash = (dt_on[0] && dt_on[2]) || (dt_on[1] && dt_on[3]);

   // ====================
   // state override
   // ====================
   always_comb begin
      case (i_state)
         BR_BOOT:      q_d = 4'b1100;
         BR_PRECHARGE: q_d = 4'b1001;
         BR_RUN:       q_d = leg_clash ? 4'b0000 : dt_on;
         default:      q_d = 4'b0000;
      endcase
   end

   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) o_q <= '0;
      else o_q <= q_d;
   end

   a_no_shoot_through: assert property (@(posedge ADA_DCO) disable iff (!i_arst_n)
      !((o_q[0] && o_q[2]) || (o_q[1] && o_q[3])));

endmodule

//--- hw/bridge_sequencer.sv
// H-bridge start-up and protection FSM
// bootstrap charge, forced sigma, run, over-voltage shutdown
`timescale 1ns/1ps
`include "hc_consts.svh"

module bridge_sequencer import hc_pkg::*; (
   input  logic          ADA_DCO,
   input  logic          i_arst_n,
   input  logic          i_enable,
   input  bat_code_t     i_vbat_code,
   output bridge_state_t o_state,
   output logic          o_pi_clear,
   output logic          o_ov_fault
);

   bridge_state_t state_d;
   logic [7:0]    cnt_q;
   logic          enable_q;
   logic          en_rise;
   bat_code_t     vbat_volts;
   logic          ov_trip;

   // battery code to volts
   assign vbat_volts = i_vbat_code >> `HC_VBAT_SHIFT;
   assign ov_trip    = (vbat_volts > `HC_OV_VOLTS);
   assign en_rise    = i_enable && !enable_q;

   // ====================
   // next state
   // ====================
   always_comb begin
      state_d = o_state;
      case (o_state)
         BR_OFF:       if (en_rise) state_d = BR_BOOT;
         // low sides charge the bootstrap caps
         BR_BOOT:      if (cnt_q >= `HC_ON_CNT) state_d = BR_PRECHARGE;
         // sigma forced to 1 to charge the tank
         BR_PRECHARGE: if (cnt_q >= `HC_VG_CNT) state_d = BR_RUN;
         BR_RUN:       if (ov_trip) state_d = BR_OFF;
         default:      state_d = BR_OFF;
      endcase
      // disable wins over everything
      if (!i_enable) state_d = BR_OFF;
   end

   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_state    <= BR_OFF;
         cnt_q      <= '0;
         enable_q   <= 1'b0;
         o_pi_clear <= 1'b0;
         o_ov_fault <= 1'b0;
      end else begin
         o_state  <= state_d;
         enable_q <= i_enable;
         // start-up counter, frozen once running
         case (o_state)
            BR_OFF:  cnt_q <= '0;
            BR_RUN:  cnt_q <= cnt_q;
            default: cnt_q <= cnt_q + 8'd1;
         endcase
         // one pulse in the first RUN cycle
         o_pi_clear <= (state_d == BR_RUN) && (o_state != BR_RUN);
         // fault latch, released by disable
         if (!i_enable) o_ov_fault <= 1'b0;
         else if (o_state == BR_RUN && ov_trip) o_ov_fault <= 1'b1;
      end
   end

   // run is entered only from precharge
   a_run_after_pre: assert property (@(posedge ADA_DCO) disable iff (!i_arst_n)
      (o_state == BR_RUN && $past(o_state) != BR_RUN) |-> $past(o_state) == BR_PRECHARGE);

endmodule

//--- hw/tank_adc_capture.sv
// tank ADC capture
// inverts both samples and clamps channel A on over-range
`timescale 1ns/1ps
`include "hc_consts.svh"

module tank_adc_capture import hc_pkg::*; (
   input  logic        ADA_DCO,
   input  logic        i_arst_n,
   input  adc_sample_t i_ada_data,
   input  adc_sample_t i_adb_data,
   input  logic        i_ada_or,
   output adc_sample_t o_vc,
   output adc_sample_t o_ic
);

   // extreme codes of the converter
   localparam adc_sample_t ADC_MIN = {1'b1, {(`HC_ADC_W-1){1'b0}}};
   localparam adc_sample_t ADC_MAX = {1'b0, {(`HC_ADC_W-1){1'b1}}};

   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_vc <= '0;
         o_ic <= '0;
      end else begin
         // sensor polarity is inverted on the board
         if (i_ada_or) begin
            // the negative end flips to the positive one
            o_vc <= (i_ada_data == ADC_MIN) ? ADC_MAX : ADC_MIN;
         end else begin
            o_vc <= -i_ada_data;
         end
         o_ic <= -i_adb_data;
      end
   end

   // most negative output only under over-range
   a_vc_min_from_or: assert property (@(posedge ADA_DCO) disable iff (!i_arst_n)
      (o_vc == ADC_MIN) |-> $past(i_ada_or));

endmodule

//--- hw/hc_pkg.sv
// shared types of the resonant converter power stage
`include "hc_consts.svh"

package hc_pkg;

   // tank sample, two's complement
   typedef logic signed [`HC_ADC_W-1:0] adc_sample_t;

   // raw battery ADC code
   typedef logic [`HC_BAT_W-1:0] bat_code_t;

   // bit0 M1, bit1 M2, bit2 M3, bit3 M4
   // legs are M1/M3 and M2/M4
   typedef logic [3:0] gate_t;

   // H-bridge start-up states
   typedef enum logic [1:0] {
      BR_OFF,
      BR_BOOT,
      BR_PRECHARGE,
      BR_RUN
   } bridge_state_t;

   typedef logic signed [31:0] ctrl_word_t;
   typedef logic [7:0] phi_t;

endpackage

//--- hw/hc_consts.svh
// resonant converter power stage constants
// widths, start-up thresholds, PI gains and dead-time table
`ifndef HC_CONSTS_SVH
`define HC_CONSTS_SVH

// data widths
`define HC_ADC_W 14
`define HC_BAT_W 8

// start-up counts, bootstrap then forced sigma
`define HC_ON_CNT 10
`define HC_VG_CNT 14

// battery voltage, volts = code >> shift
`define HC_OV_VOLTS 50
`define HC_VBAT_SHIFT 2

// battery current scaling
`define HC_IBAT_MA_LSB 40
`define HC_IREF_SCALE 100
`define HC_ERR_ROUND_SHIFT 7

// PI gains as multiply then shift
`define HC_KP 3
`define HC_KP_SHIFT 14
`define HC_KI 1
`define HC_KI_SHIFT 16
`define HC_PHI_OFFSET 50
`define HC_PHI_MAX 70

// dead time in clock cycles, indexed by select code
`define HC_DT_00 80
`define HC_DT_10 20
`define HC_DT_01 40
`define HC_DT_11 60
`define HC_DT_W 7

`endif
